//--- flist.f
design/mips_pkg.sv
design/control.sv
design/registers.sv
design/decode.sv
design/id_ex_reg.sv
design/decode_top.sv
bench/decode_tb.sv

//--- Bender.yml
package:
  name: mips_decode

sources:
  # Package first, then leaf modules up to the top level
  - files:
      - design/mips_pkg.sv
      - design/control.sv
      - design/registers.sv
      - design/decode.sv
      - design/id_ex_reg.sv
      - design/decode_top.sv

  - target: simulation
    files:
      - bench/decode_tb.sv

//--- bench/decode_tb.sv
`timescale 1ns/10ps

module decode_tb;

	// Stimulus first, expected bundle last
	typedef struct packed {
		logic [mips_pkg::DATA_W-1:0] pc;
		logic [31:0]                 instr;
		mips_pkg::wb_port_t          wb;
		logic                        stall;
		logic                        flush;
		mips_pkg::id_ex_t            exp;
	} row_t;

	logic                        clk;
	logic                        arst_n;
	logic [mips_pkg::DATA_W-1:0] pc_next;
	mips_pkg::instr_u            instr;
	mips_pkg::wb_port_t          wb;
	logic                        stall;
	logic                        flush;
	mips_pkg::id_ex_t            id_ex;

	row_t                        tbl[$];
	logic [mips_pkg::DATA_W-1:0] model [0:mips_pkg::NUM_REGS-1];
	integer                      seed;
	int                          cur_row;
	bit                          table_ready;

	decode_top dut0 (
		.clk     (clk),
		.arst_n  (arst_n),
		.pc_next (pc_next),
		.instr   (instr),
		.wb      (wb),
		.stall   (stall),
		.flush   (flush),
		.id_ex   (id_ex)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Instruction words and expected control
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] rtype_word(input logic [4:0] rs, rt, rd, sh,
		input logic [5:0] fn);
		return {mips_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Control columns: reg_dst alu_src alu_op | branch mem_read mem_write | reg_write mem_to_reg | illegal
	function automatic mips_pkg::ctrl_t rtype_ctrl(input logic [2:0] op);
		return {2'b10, op, 3'b000, 2'b10, 1'b0};
	endfunction

	task automatic add_row(input logic [31:0] pc, input logic [31:0] word,
		input mips_pkg::ctrl_t ctrl, input mips_pkg::wb_port_t w, input logic st, fl);
		row_t               r;
		logic signed [15:0] imm;
		r.pc    = pc;
		r.instr = word;
		r.wb    = w;
		r.stall = st;
		r.flush = fl;
		imm     = word[15:0];
		if (fl)
			r.exp = '0;
		else if (st)
			r.exp = (tbl.size() > 0) ? tbl[$].exp : '0;
		else
		begin
			r.exp.pc_branch = pc;
			r.exp.pc_jump   = (pc & 32'hf000_0000) | (32'(word[25:0]) << 2);
			r.exp.reg1      = model[word[25:21]];
			r.exp.reg2      = model[word[20:16]];
			r.exp.sign_ext  = 32'(imm);
			r.exp.rt        = word[20:16];
			r.exp.rd        = word[15:11];
			r.exp.shamt     = word[10:6];
			r.exp.ctrl      = ctrl;
		end
		// Write lands at the end of the row, visible from the next row on
		if (w.we && (w.addr != 5'd0))
			model[w.addr] = w.data;
		tbl.push_back(r);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic build_table();
		int                 r;
		mips_pkg::wb_port_t w;
		mips_pkg::ctrl_t    add_c;
		mips_pkg::ctrl_t    bad_c;
		add_c = rtype_ctrl(mips_pkg::ALU_ADD);
		bad_c = 11'b0_0_000_000_00_1;
		// Row N writes rN, reads r(N-1) from the row before and the old rN
		for (r = 1; r < mips_pkg::NUM_REGS; r++)
		begin
			w = {1'b1, 5'(r), 32'($random(seed))};
			add_row(32'h0040_0000 + 32'(4 * r),
				rtype_word(5'(r - 1), 5'(r), 5'(r), 5'd0, mips_pkg::FN_ADD), add_c, w, 0, 0);
		end
		// r31 read back, then a write to r0 that must not stick
		w = {1'b1, 5'd0, 32'($random(seed))};
		add_row(32'h0040_0100, rtype_word(31, 0, 1, 0, mips_pkg::FN_ADD), add_c, w, 0, 0);
		add_row(32'h0040_0104, rtype_word(0, 30, 2, 0, mips_pkg::FN_ADD), add_c, '0, 0, 0);

		add_row(32'h0040_0108, rtype_word(1, 2, 3, 0, mips_pkg::FN_SUB),
			rtype_ctrl(mips_pkg::ALU_SUB), '0, 0, 0);
		add_row(32'h0040_010c, rtype_word(4, 5, 6, 0, mips_pkg::FN_AND),
			rtype_ctrl(mips_pkg::ALU_AND), '0, 0, 0);
		add_row(32'h0040_0110, rtype_word(7, 8, 9, 0, mips_pkg::FN_OR),
			rtype_ctrl(mips_pkg::ALU_OR), '0, 0, 0);
		add_row(32'h0040_0114, rtype_word(10, 11, 12, 0, mips_pkg::FN_SLT),
			rtype_ctrl(mips_pkg::ALU_SLT), '0, 0, 0);
		add_row(32'h0040_0118, rtype_word(0, 9, 10, 17, mips_pkg::FN_SLL),
			rtype_ctrl(mips_pkg::ALU_SLL), '0, 0, 0);
		add_row(32'h0040_011c, rtype_word(0, 13, 14, 31, mips_pkg::FN_SRL),
			rtype_ctrl(mips_pkg::ALU_SRL), '0, 0, 0);

		// Negative and positive immediates mixed over the I-types
		add_row(32'h0040_0120, itype_word(mips_pkg::OP_LW, 5, 6, 16'h0010),
			{2'b01, mips_pkg::ALU_ADD, 3'b010, 2'b11, 1'b0}, '0, 0, 0);
		add_row(32'h0040_0124, itype_word(mips_pkg::OP_SW, 7, 8, 16'hfffc),
			{2'b01, mips_pkg::ALU_ADD, 3'b001, 2'b00, 1'b0}, '0, 0, 0);
		add_row(32'h0040_0128, itype_word(mips_pkg::OP_BEQ, 1, 2, 16'h7ffe),
			{2'b00, mips_pkg::ALU_SUB, 3'b100, 2'b00, 1'b0}, '0, 0, 0);
		add_row(32'h0040_012c, itype_word(mips_pkg::OP_ADDI, 3, 4, 16'h8000),
			{2'b01, mips_pkg::ALU_ADD, 3'b000, 2'b10, 1'b0}, '0, 0, 0);

		// Two stalled rows hold the addi bundle, flush beats stall
		add_row(32'h0040_0130, rtype_word(1, 2, 3, 0, mips_pkg::FN_SUB), add_c, '0, 1, 0);
		add_row(32'h0040_0134, itype_word(mips_pkg::OP_LW, 2, 3, 16'h0004), add_c, '0, 1, 0);
		add_row(32'h0040_0138, itype_word(mips_pkg::OP_SW, 4, 5, 16'h0008), add_c, '0, 1, 1);

		add_row(32'ha000_0040, {mips_pkg::OP_J, 26'h3ff_fffe}, '0, '0, 0, 0);
		add_row(32'h0040_0140, itype_word(6'h3f, 1, 2, 16'h1234), bad_c, '0, 0, 0);
		add_row(32'h0040_0144, rtype_word(1, 2, 3, 0, 6'h3f), bad_c, '0, 0, 0);
		add_row(32'h0040_0148, 32'h0000_0000, '0, '0, 0, 0);
		add_row(32'h0040_014c, rtype_word(20, 21, 22, 0, mips_pkg::FN_ADD), add_c, '0, 0, 0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Drive and compare
	//////////////////////////////////////////////////////////////////////

	task automatic apply_row(input row_t r);
		pc_next <= r.pc;
		instr   <= r.instr;
		wb      <= r.wb;
		stall   <= r.stall;
		flush   <= r.flush;
	endtask

	task automatic check_value(input string name, input logic [31:0] got, exp);
		if (got !== exp)
		begin
			$display("[FAIL] row %0d %s: got 0x%0h, expected 0x%0h", cur_row, name, got, exp);
			$display("Some tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic compare_bundle(input mips_pkg::id_ex_t exp);
		check_value("id_ex.pc_branch", id_ex.pc_branch, exp.pc_branch);
		check_value("id_ex.pc_jump", id_ex.pc_jump, exp.pc_jump);
		check_value("id_ex.reg1", id_ex.reg1, exp.reg1);
		check_value("id_ex.reg2", id_ex.reg2, exp.reg2);
		check_value("id_ex.sign_ext", id_ex.sign_ext, exp.sign_ext);
		check_value("id_ex.rt", 32'(id_ex.rt), 32'(exp.rt));
		check_value("id_ex.rd", 32'(id_ex.rd), 32'(exp.rd));
		check_value("id_ex.shamt", 32'(id_ex.shamt), 32'(exp.shamt));
		check_value("id_ex.ctrl", 32'(id_ex.ctrl), 32'(exp.ctrl));
	endtask

	initial
	begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		pc_next     = '0;
		instr       = '0;
		wb          = '0;
		stall       = 1'b0;
		flush       = 1'b0;
		seed        = 39810;
		cur_row     = -1;
		table_ready = 1'b0;
		foreach (model[k])
			model[k] = '0;
		build_table();
		table_ready = 1'b1;

		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		// Row -1 stands for the reset state
		@(negedge clk);
		compare_bundle('0);

		// Result of row i shows on id_ex during row i+1
		for (int i = 0; i < tbl.size(); i++)
		begin
			@(posedge clk);
			apply_row(tbl[i]);
			@(negedge clk);
			if (i > 0)
			begin
				cur_row = i - 1;
				compare_bundle(tbl[i - 1].exp);
			end
		end
		@(posedge clk);
		apply_row('0);
		@(negedge clk);
		cur_row = tbl.size() - 1;
		compare_bundle(tbl[$].exp);

		$display("All tests passed");
		$finish;
	end

	// Reset, one cycle per row and some slack
	initial
	begin
		wait (table_ready);
		#((tbl.size() + 10) * 10);
		$display("Timeout: the run did not reach the end of the table in time");
		$display("Some tests failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

//--- design/decode_top.sv
`timescale 1ns/10ps

module decode_top (
	input                                   clk,
	input                                   arst_n,
	input        [mips_pkg::DATA_W-1:0]     pc_next,
	input  mips_pkg::instr_u                instr,
	input  mips_pkg::wb_port_t              wb,
	input                                   stall,
	input                                   flush,
	output mips_pkg::id_ex_t                id_ex
);

	// Combinational decode result ahead of the stage register
	mips_pkg::id_ex_t id_bundle;

	decode u_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.pc_next   (pc_next),
		.instr     (instr),
		.wb        (wb),
		.id_bundle (id_bundle)
	);

	id_ex_reg u_id_ex_reg (
		.clk       (clk),
		.arst_n    (arst_n),
		.stall     (stall),
		.flush     (flush),
		.id_bundle (id_bundle),
		.id_ex     (id_ex)
	);

endmodule

//--- design/id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg (
	input                    clk,
	input                    arst_n,
	input                    stall,
	input                    flush,
	input  mips_pkg::id_ex_t id_bundle,
	output mips_pkg::id_ex_t id_ex
);

	//////////////////////////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////////////////////////

	// Flush takes priority, a bubble goes in even while stalled
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			id_ex <= '0;
		end
		else if (flush)
		begin
			id_ex <= '0;
		end
		else if (!stall)
		begin
			id_ex <= id_bundle;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Bubble carries no control into execute
	flush_bubble_a: assert property (@(posedge clk) disable iff (!arst_n)
		flush |=> (id_ex.ctrl == '0))
		else $error("id_ex_reg: control not cleared after flush");

	// Held bundle does not move under stall
	stall_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
		(stall && !flush) |=> $stable(id_ex))
		else $error("id_ex_reg: bundle changed during stall");

endmodule

//--- design/decode.sv
`timescale 1ns/10ps

module decode (
	input                                   clk,
	input                                   arst_n,
	input        [mips_pkg::DATA_W-1:0]     pc_next,
	input  mips_pkg::instr_u                instr,
	input  mips_pkg::wb_port_t              wb,
	output mips_pkg::id_ex_t                id_bundle
);

	mips_pkg::ctrl_t             ctrl;
	logic [mips_pkg::DATA_W-1:0] rs_data;
	logic [mips_pkg::DATA_W-1:0] rt_data;

	//////////////////////////////////////////////////////////////////////
	// Control and register file
	//////////////////////////////////////////////////////////////////////

	control u_control (
		.instr (instr),
		.ctrl  (ctrl)
	);

	registers u_registers (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs_addr (instr.r.rs),
		.rt_addr (instr.r.rt),
		.wb      (wb),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Bundle assembly
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		id_bundle.pc_branch = pc_next;

		// Region of the next PC plus word-aligned target
		id_bundle.pc_jump = {pc_next[31:28], instr.j.target, 2'b00};

		id_bundle.reg1 = rs_data;
		id_bundle.reg2 = rt_data;

		// Immediate, sign-extended from 16 bits
		id_bundle.sign_ext = {{16{instr.i.imm[15]}}, instr.i.imm};

		id_bundle.rt    = instr.r.rt;
		id_bundle.rd    = instr.r.rd;
		id_bundle.shamt = instr.r.shamt;
		id_bundle.ctrl  = ctrl;
	end

endmodule

//--- design/registers.sv
`timescale 1ns/10ps

module registers (
	input                                   clk,
	input                                   arst_n,
	input        [mips_pkg::REG_AW-1:0]     rs_addr,
	input        [mips_pkg::REG_AW-1:0]     rt_addr,
	input  mips_pkg::wb_port_t              wb,
	output logic [mips_pkg::DATA_W-1:0]     rs_data,
	output logic [mips_pkg::DATA_W-1:0]     rt_data
);

	// Entry zero is cleared by reset and skipped by the write port
	logic [mips_pkg::DATA_W-1:0] regs [0:mips_pkg::NUM_REGS-1];

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int k = 0; k < mips_pkg::NUM_REGS; k++)
				regs[k] <= '0;
		end
		else if (wb.we && (wb.addr != '0))
		begin
			regs[wb.addr] <= wb.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read ports without write bypass
	//////////////////////////////////////////////////////////////////////

	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

	// r0 reads zero on both ports even after a write aimed at it
	zero_read_a: assert property (@(posedge clk) disable iff (!arst_n)
		((rs_addr == '0) |-> (rs_data == '0)) and ((rt_addr == '0) |-> (rt_data == '0)))
		else $error("registers: r0 read returned nonzero");

endmodule

//--- design/control.sv
`timescale 1ns/10ps

module control (
	input  mips_pkg::instr_u instr,
	output mips_pkg::ctrl_t  ctrl
);

	logic       is_nop;
	logic       fn_ok;
	logic [2:0] fn_op;

	// All-zero word decodes as sll r0 but is treated as a plain nop
	assign is_nop = (instr == '0);

	//////////////////////////////////////////////////////////////////////
	// Funct decode for R-type
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		fn_ok = 1'b1;
		case (instr.r.funct)
			mips_pkg::FN_ADD: fn_op = mips_pkg::ALU_ADD;
			mips_pkg::FN_SUB: fn_op = mips_pkg::ALU_SUB;
			mips_pkg::FN_AND: fn_op = mips_pkg::ALU_AND;
			mips_pkg::FN_OR:  fn_op = mips_pkg::ALU_OR;
			mips_pkg::FN_SLT: fn_op = mips_pkg::ALU_SLT;
			mips_pkg::FN_SLL: fn_op = mips_pkg::ALU_SLL;
			mips_pkg::FN_SRL: fn_op = mips_pkg::ALU_SRL;
			default:
			begin
				fn_op = mips_pkg::ALU_ADD;
				fn_ok = 1'b0;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Main decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		ctrl = '0;
		if (!is_nop)
		begin
			case (instr.r.opcode)
				mips_pkg::OP_RTYPE:
				begin
					if (fn_ok)
					begin
						ctrl.ex.reg_dst   = 1'b1;
						ctrl.ex.alu_op    = fn_op;
						ctrl.wb.reg_write = 1'b1;
					end
					else
						ctrl.illegal = 1'b1;
				end
				mips_pkg::OP_LW:
				begin
					ctrl.ex.alu_src    = 1'b1;
					ctrl.ex.alu_op     = mips_pkg::ALU_ADD;
					ctrl.mem.mem_read  = 1'b1;
					ctrl.wb.reg_write  = 1'b1;
					ctrl.wb.mem_to_reg = 1'b1;
				end
				mips_pkg::OP_SW:
				begin
					ctrl.ex.alu_src    = 1'b1;
					ctrl.ex.alu_op     = mips_pkg::ALU_ADD;
					ctrl.mem.mem_write = 1'b1;
				end
				mips_pkg::OP_BEQ:
				begin
					ctrl.ex.alu_op  = mips_pkg::ALU_SUB;
					ctrl.mem.branch = 1'b1;
				end
				mips_pkg::OP_ADDI:
				begin
					ctrl.ex.alu_src   = 1'b1;
					ctrl.ex.alu_op    = mips_pkg::ALU_ADD;
					ctrl.wb.reg_write = 1'b1;
				end
				// Jump target is formed in decode, nothing to enable here
				mips_pkg::OP_J: ctrl = '0;
				default: ctrl.illegal = 1'b1;
			endcase
		end
	end

	// A load and a store never share one instruction
	mem_excl_a: assert #0 (!(ctrl.mem.mem_read && ctrl.mem.mem_write))
		else $error("control: mem_read and mem_write both high");

endmodule

//--- design/mips_pkg.sv
package mips_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int DATA_W   = 32;
	localparam int REG_AW   = 5;
	localparam int NUM_REGS = 32;

	// Major opcodes, bits 31:26
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_J     = 6'h02;

	// R-type function codes, bits 5:0
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;

	// ALU operations seen by the execute stage
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR  = 3'd3;
	localparam logic [2:0] ALU_SLT = 3'd4;
	localparam logic [2:0] ALU_SLL = 3'd5;
	localparam logic [2:0] ALU_SRL = 3'd6;

	//////////////////////////////////////////////////////////////////////
	// Instruction formats
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0]        opcode;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] rd;
		logic [4:0]        shamt;
		logic [5:0]        funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]        opcode;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [15:0]       imm;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_fmt_t;

	// Same 32-bit word, three views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

	//////////////////////////////////////////////////////////////////////
	// Control groups and stage bundle
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic       reg_dst;
		logic       alu_src;
		logic [2:0] alu_op;
	} ex_ctrl_t;

	typedef struct packed {
		logic branch;
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
		logic      illegal;
	} ctrl_t;

	typedef struct packed {
		logic              we;
		logic [REG_AW-1:0] addr;
		logic [DATA_W-1:0] data;
	} wb_port_t;

	typedef struct packed {
		logic [DATA_W-1:0] pc_branch;
		logic [DATA_W-1:0] pc_jump;
		logic [DATA_W-1:0] reg1;
		logic [DATA_W-1:0] reg2;
		logic [DATA_W-1:0] sign_ext;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] shamt;
		ctrl_t             ctrl;
	} id_ex_t;

endpackage
